/* hw/tile_config.svh */
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define TILE_PLEN 32
`define TILE_XLEN 32

////////////////////////////////////////
// Memory sizes
////////////////////////////////////////

// Local data memory, must be a power of two
`define TILE_LMEM_SIZE_BYTE 1024

// Boot image length in words, power of two
`define TILE_BOOTROM_WORDS 8

////////////////////////////////////////
// Address map, top address nibble
////////////////////////////////////////

`define TILE_DM_MATCH 4'h0
`define TILE_BOOT_MATCH 4'hf

`endif

/* hw/ahb3_pkg.sv */
`include "tile_config.svh"

package ahb3_pkg;

  ////////////////////////////////////////
  // Basic bus types
  ////////////////////////////////////////

  typedef logic [`TILE_PLEN-1:0] addr_t;
  typedef logic [`TILE_XLEN-1:0] word_t;

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // HSIZE, nothing wider than the data bus
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Two-cycle ERROR response sequence
  typedef enum logic [1:0] {
    ERR_IDLE,
    ERR_FIRST,
    ERR_SECOND
  } err_state_e;

  ////////////////////////////////////////
  // Address phase and response bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic    hsel;
    addr_t   haddr;
    logic    hwrite;
    hsize_e  hsize;
    htrans_e htrans;
  } ahb3_req_t;

  typedef struct packed {
    word_t  hrdata;
    logic   hready;
    hresp_e hresp;
  } ahb3_rsp_t;

endpackage

/* hw/tile_map_pkg.sv */
`include "tile_config.svh"

package tile_map_pkg;

  // Slaves on the tile bus, SLV_NONE for holes in the map
  typedef enum logic [1:0] {
    SLV_DM,
    SLV_BOOT,
    SLV_NONE
  } slave_e;

  ////////////////////////////////////////
  // Boot image
  ////////////////////////////////////////

  // Minimal start-up, set up a stack and jump into local memory
  localparam ahb3_pkg::word_t boot_image [`TILE_BOOTROM_WORDS] = '{
    32'h0000_0093,  // addi ra, zero, 0
    32'h0000_1137,  // lui  sp, 0x1
    32'hff01_0113,  // addi sp, sp, -16
    32'hf140_2573,  // csrr a0, mhartid
    32'h0000_0293,  // addi t0, zero, 0
    32'h0002_8067,  // jr   t0
    32'h1050_0073,  // wfi
    32'h0000_006f   // j    .
  };

  // Address map lookup on the top nibble
  function automatic slave_e slave_decode(ahb3_pkg::addr_t addr);
    case (addr[`TILE_PLEN-1 -: 4])
      `TILE_DM_MATCH:   return SLV_DM;
      `TILE_BOOT_MATCH: return SLV_BOOT;
      default:          return SLV_NONE;
    endcase
  endfunction

endpackage

/* hw/ahb3_interconnect.sv */
`timescale 1ns/1ps

module ahb3_interconnect (
  input  logic                clk,
  input  logic                arst_n_i,

  // Master side
  input  ahb3_pkg::ahb3_req_t m_req_i,
  output ahb3_pkg::ahb3_rsp_t m_rsp_o,

  // Slave side
  output ahb3_pkg::ahb3_req_t dm_req_o,
  output ahb3_pkg::ahb3_req_t boot_req_o,
  input  ahb3_pkg::ahb3_rsp_t dm_rsp_i,
  input  ahb3_pkg::ahb3_rsp_t boot_rsp_i,

  // Bus ready, seen by every slave
  output logic                hready_o
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  tile_map_pkg::slave_e addr_slv;
  tile_map_pkg::slave_e data_slv;
  logic                 addr_accept;
  ahb3_pkg::err_state_e err_state;
  ahb3_pkg::err_state_e err_state_next;

  ////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////

  assign addr_slv = tile_map_pkg::slave_decode(m_req_i.haddr);

  assign addr_accept = hready_o && m_req_i.hsel &&
                       (m_req_i.htrans == ahb3_pkg::NONSEQ ||
                        m_req_i.htrans == ahb3_pkg::SEQ);

  // Same request to both slaves, only hsel differs
  always_comb begin
    dm_req_o        = m_req_i;
    dm_req_o.hsel   = m_req_i.hsel && (addr_slv == tile_map_pkg::SLV_DM);
    boot_req_o      = m_req_i;
    boot_req_o.hsel = m_req_i.hsel && (addr_slv == tile_map_pkg::SLV_BOOT);
  end

  // Slave owning the data phase, SLV_NONE when the bus is idle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_slv <= tile_map_pkg::SLV_NONE;
    end else if (hready_o) begin
      data_slv <= addr_accept ? addr_slv : tile_map_pkg::SLV_NONE;
    end
  end

  ////////////////////////////////////////
  // Error responder for unmapped space
  ////////////////////////////////////////

  always_comb begin
    case (err_state)
      ahb3_pkg::ERR_FIRST: begin
        err_state_next = ahb3_pkg::ERR_SECOND;
      end
      // Idle and second cycle both have hready high
      default: begin
        if (addr_accept && addr_slv == tile_map_pkg::SLV_NONE) begin
          err_state_next = ahb3_pkg::ERR_FIRST;
        end else begin
          err_state_next = ahb3_pkg::ERR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_state <= ahb3_pkg::ERR_IDLE;
    end else begin
      err_state <= err_state_next;
    end
  end

  ////////////////////////////////////////
  // Data phase response mux
  ////////////////////////////////////////

  always_comb begin
    m_rsp_o.hrdata = '0;
    m_rsp_o.hready = 1'b1;
    m_rsp_o.hresp  = ahb3_pkg::OKAY;
    case (err_state)
      ahb3_pkg::ERR_FIRST: begin
        m_rsp_o.hready = 1'b0;
        m_rsp_o.hresp  = ahb3_pkg::ERROR;
      end
      ahb3_pkg::ERR_SECOND: begin
        m_rsp_o.hresp = ahb3_pkg::ERROR;
      end
      default: begin
        case (data_slv)
          tile_map_pkg::SLV_DM:   m_rsp_o = dm_rsp_i;
          tile_map_pkg::SLV_BOOT: m_rsp_o = boot_rsp_i;
          default:                m_rsp_o.hresp = ahb3_pkg::OKAY;
        endcase
      end
    endcase
  end

  assign hready_o = m_rsp_o.hready;

  // Boot ROM stays quiet unless it owns the data phase
  a_boot_rsp_owner: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (data_slv != tile_map_pkg::SLV_BOOT) |->
      (boot_rsp_i.hready && boot_rsp_i.hresp == ahb3_pkg::OKAY)
  );

endmodule

/* hw/ahb3_sram_sp.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module ahb3_sram_sp (
  input  logic                clk,
  input  logic                arst_n_i,
  input  ahb3_pkg::ahb3_req_t req_i,
  input  ahb3_pkg::word_t     hwdata_i,
  input  logic                hready_i,
  output ahb3_pkg::ahb3_rsp_t rsp_o
);

  localparam int unsigned LANES = `TILE_XLEN / 8;
  localparam int unsigned OFF_W = $clog2(LANES);
  localparam int unsigned WORDS = `TILE_LMEM_SIZE_BYTE / LANES;
  localparam int unsigned IDX_W = $clog2(WORDS);

  ////////////////////////////////////////
  // Storage and data phase state
  ////////////////////////////////////////

  ahb3_pkg::word_t  mem [WORDS];
  logic             accept;
  logic [LANES-1:0] addr_be;
  logic             dp_write;
  logic [LANES-1:0] dp_be;
  logic [IDX_W-1:0] dp_idx;

  assign accept = req_i.hsel && hready_i &&
                  (req_i.htrans == ahb3_pkg::NONSEQ || req_i.htrans == ahb3_pkg::SEQ);

  // Byte lanes from size and low address bits
  always_comb begin
    case (req_i.hsize)
      ahb3_pkg::BYTE: addr_be = LANES'(1) << req_i.haddr[OFF_W-1:0];
      ahb3_pkg::HALF: addr_be = LANES'(3) << {req_i.haddr[OFF_W-1:1], 1'b0};
      ahb3_pkg::WORD: addr_be = '1;
      default:        addr_be = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_write <= 1'b0;
    end else if (hready_i) begin
      dp_write <= accept && req_i.hwrite;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dp_idx <= req_i.haddr[IDX_W+OFF_W-1:OFF_W];
      dp_be  <= addr_be;
    end
  end

  ////////////////////////////////////////
  // Write at the end of the data phase
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (dp_write && hready_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (dp_be[i])
          mem[dp_idx][8*i +: 8] <= hwdata_i[8*i +: 8];
      end
    end
  end

  // Zero wait states, read straight from the registered address
  always_comb begin
    rsp_o.hrdata = mem[dp_idx];
    rsp_o.hready = 1'b1;
    rsp_o.hresp  = ahb3_pkg::OKAY;
  end

  a_size_le_word: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    accept |-> (req_i.hsize <= ahb3_pkg::WORD)
  );

endmodule

/* hw/ahb3_bootrom.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module ahb3_bootrom (
  input  logic                clk,
  input  logic                arst_n_i,
  input  ahb3_pkg::ahb3_req_t req_i,
  input  logic                hready_i,
  output ahb3_pkg::ahb3_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(`TILE_BOOTROM_WORDS);

  logic                 accept;
  logic [IDX_W-1:0]     dp_idx;
  ahb3_pkg::err_state_e state;
  ahb3_pkg::err_state_e state_next;

  assign accept = req_i.hsel && hready_i &&
                  (req_i.htrans == ahb3_pkg::NONSEQ || req_i.htrans == ahb3_pkg::SEQ);

  // Word index wraps over the image
  always_ff @(posedge clk) begin
    if (accept) begin
      dp_idx <= req_i.haddr[IDX_W+1:2];
    end
  end

  ////////////////////////////////////////
  // Write rejection
  ////////////////////////////////////////

  always_comb begin
    case (state)
      ahb3_pkg::ERR_FIRST: begin
        state_next = ahb3_pkg::ERR_SECOND;
      end
      default: begin
        if (accept && req_i.hwrite) begin
          state_next = ahb3_pkg::ERR_FIRST;
        end else begin
          state_next = ahb3_pkg::ERR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= ahb3_pkg::ERR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    rsp_o.hrdata = '0;
    rsp_o.hready = 1'b1;
    rsp_o.hresp  = ahb3_pkg::OKAY;
    case (state)
      ahb3_pkg::ERR_FIRST: begin
        rsp_o.hready = 1'b0;
        rsp_o.hresp  = ahb3_pkg::ERROR;
      end
      ahb3_pkg::ERR_SECOND: rsp_o.hresp = ahb3_pkg::ERROR;
      default: rsp_o.hrdata = tile_map_pkg::boot_image[dp_idx];
    endcase
  end

  // Only one stall cycle per error
  a_single_stall: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !hready_i |=> hready_i
  );

endmodule

/* hw/ahb3_tile.sv */
`timescale 1ns/1ps

module ahb3_tile (
  input  logic                clk,
  input  logic                arst_n_i,

  // External AHB-Lite master port
  input  ahb3_pkg::ahb3_req_t req_i,
  input  ahb3_pkg::word_t     hwdata_i,
  output ahb3_pkg::ahb3_rsp_t rsp_o
);

  ////////////////////////////////////////
  // Slave side wires
  ////////////////////////////////////////

  ahb3_pkg::ahb3_req_t dm_req;
  ahb3_pkg::ahb3_req_t boot_req;
  ahb3_pkg::ahb3_rsp_t dm_rsp;
  ahb3_pkg::ahb3_rsp_t boot_rsp;
  logic                bus_hready;

  ahb3_interconnect u_bus (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .m_req_i   (req_i),
    .m_rsp_o   (rsp_o),
    .dm_req_o  (dm_req),
    .boot_req_o(boot_req),
    .dm_rsp_i  (dm_rsp),
    .boot_rsp_i(boot_rsp),
    .hready_o  (bus_hready)
  );

  // Local data memory at nibble 0x0
  ahb3_sram_sp u_ram (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .req_i   (dm_req),
    .hwdata_i(hwdata_i),
    .hready_i(bus_hready),
    .rsp_o   (dm_rsp)
  );

  // Boot ROM at nibble 0xf
  ahb3_bootrom u_bootrom (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .req_i   (boot_req),
    .hready_i(bus_hready),
    .rsp_o   (boot_rsp)
  );

endmodule

/* verification/tb_ahb3_tile.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module tb_ahb3_tile;

  localparam int LANES      = `TILE_XLEN / 8;
  localparam int LMEM_WORDS = `TILE_LMEM_SIZE_BYTE / LANES;

  // One bus transfer with its expected response
  typedef struct packed {
    logic             hwrite;
    ahb3_pkg::addr_t  addr;
    ahb3_pkg::hsize_e size;
    ahb3_pkg::word_t  wdata;
    ahb3_pkg::word_t  exp_data;
    ahb3_pkg::hresp_e exp_resp;
  } vec_t;

  logic                clk;
  logic                arst_n_i;
  ahb3_pkg::ahb3_req_t req_i;
  ahb3_pkg::word_t     hwdata_i;
  ahb3_pkg::ahb3_rsp_t rsp_o;

  vec_t            vec_q [$];
  string           name_q [$];
  ahb3_pkg::word_t ref_mem [LMEM_WORDS];
  integer          seed = 32;
  int              cycle_cnt = 0;
  int              cycle_limit = 0;

  ahb3_tile u_ahb3_tile (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .req_i   (req_i),
    .hwdata_i(hwdata_i),
    .rsp_o   (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure handling and compare tasks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input ahb3_pkg::word_t exp,
                            input ahb3_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: hrdata expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input ahb3_pkg::hresp_e exp,
                            input ahb3_pkg::hresp_e act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: hresp expected %s, actual %s (%b)",
                          name, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: hready expected %b, actual %b", name, exp, act));
    end
  endtask

  // Stop a run that stops making progress
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      abort_run("Run timed out before all transfers completed");
    end
  end

  ////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////

  // AHB byte lanes for a little-endian 32-bit bus
  function automatic logic [LANES-1:0] lane_mask(input ahb3_pkg::addr_t addr,
                                                 input ahb3_pkg::hsize_e size);
    case (size)
      ahb3_pkg::BYTE: return 4'b0001 << addr[1:0];
      ahb3_pkg::HALF: return 4'b0011 << {addr[1], 1'b0};
      default:        return 4'b1111;
    endcase
  endfunction

  task automatic add_vec(input string name, input logic wr, input ahb3_pkg::addr_t addr,
                         input ahb3_pkg::hsize_e size, input ahb3_pkg::word_t wdata);
    vec_t             v;
    logic [3:0]       nib;
    int               idx;
    logic [LANES-1:0] lanes;
    v.hwrite   = wr;
    v.addr     = addr;
    v.size     = size;
    v.wdata    = wdata;
    v.exp_data = '0;
    v.exp_resp = ahb3_pkg::OKAY;
    nib = addr[`TILE_PLEN-1 -: 4];
    if (nib == `TILE_DM_MATCH) begin
      idx = (addr >> 2) % LMEM_WORDS;
      if (wr) begin
        lanes = lane_mask(addr, size);
        for (int i = 0; i < LANES; i++) begin
          if (lanes[i])
            ref_mem[idx][8*i +: 8] = wdata[8*i +: 8];
        end
      end else begin
        v.exp_data = ref_mem[idx];
      end
    end else if (nib == `TILE_BOOT_MATCH && !wr) begin
      v.exp_data = tile_map_pkg::boot_image[(addr >> 2) % `TILE_BOOTROM_WORDS];
    end else begin
      // ROM writes and holes in the map
      v.exp_resp = ahb3_pkg::ERROR;
    end
    vec_q.push_back(v);
    name_q.push_back(name);
  endtask

  task automatic build_table();
    add_vec("wr_w0",     1, 32'h0000_0000, ahb3_pkg::WORD, $random(seed));
    add_vec("wr_w4",     1, 32'h0000_0004, ahb3_pkg::WORD, $random(seed));
    add_vec("wr_w8",     1, 32'h0000_0008, ahb3_pkg::WORD, $random(seed));
    add_vec("wr_wc",     1, 32'h0000_000c, ahb3_pkg::WORD, $random(seed));
    add_vec("wr_w100",   1, 32'h0000_0100, ahb3_pkg::WORD, $random(seed));
    add_vec("rd_w0",     0, 32'h0000_0000, ahb3_pkg::WORD, '0);
    add_vec("rd_w4",     0, 32'h0000_0004, ahb3_pkg::WORD, '0);
    add_vec("rd_w8",     0, 32'h0000_0008, ahb3_pkg::WORD, '0);
    add_vec("rd_wc",     0, 32'h0000_000c, ahb3_pkg::WORD, '0);
    add_vec("rd_w100",   0, 32'h0000_0100, ahb3_pkg::WORD, '0);
    add_vec("wr_b1",     1, 32'h0000_0001, ahb3_pkg::BYTE, $random(seed));
    add_vec("wr_h6",     1, 32'h0000_0006, ahb3_pkg::HALF, $random(seed));
    add_vec("wr_bb",     1, 32'h0000_000b, ahb3_pkg::BYTE, $random(seed));
    add_vec("wr_hc",     1, 32'h0000_000c, ahb3_pkg::HALF, $random(seed));
    add_vec("wr_b102",   1, 32'h0000_0102, ahb3_pkg::BYTE, $random(seed));
    add_vec("rd_mrg0",   0, 32'h0000_0000, ahb3_pkg::WORD, '0);
    add_vec("rd_mrg4",   0, 32'h0000_0004, ahb3_pkg::WORD, '0);
    add_vec("rd_mrg8",   0, 32'h0000_0008, ahb3_pkg::WORD, '0);
    add_vec("rd_mrgc",   0, 32'h0000_000c, ahb3_pkg::WORD, '0);
    add_vec("rd_mrg100", 0, 32'h0000_0100, ahb3_pkg::WORD, '0);
    for (int i = 0; i < 10; i++) begin
      add_vec($sformatf("rd_boot%0d", i), 0, 32'hf000_0000 + 4 * i, ahb3_pkg::WORD, '0);
    end
    add_vec("rd_boot_hi", 0, 32'hfabc_0018, ahb3_pkg::WORD, '0);
    add_vec("wr_boot",    1, 32'hf000_0008, ahb3_pkg::WORD, $random(seed));
    add_vec("rd_boot_ro", 0, 32'hf000_0008, ahb3_pkg::WORD, '0);
    add_vec("rd_hole3",   0, 32'h3000_0000, ahb3_pkg::WORD, '0);
    add_vec("wr_hole8",   1, 32'h8000_0010, ahb3_pkg::WORD, $random(seed));
    add_vec("rd_after_e", 0, 32'h0000_0004, ahb3_pkg::WORD, '0);
    // Read right behind a write to the same word
    add_vec("b2b_wr200",  1, 32'h0000_0200, ahb3_pkg::WORD, $random(seed));
    add_vec("b2b_rd200",  0, 32'h0000_0200, ahb3_pkg::WORD, '0);
    add_vec("b2b_wrh202", 1, 32'h0000_0202, ahb3_pkg::HALF, $random(seed));
    add_vec("b2b_rdh200", 0, 32'h0000_0200, ahb3_pkg::WORD, '0);
    add_vec("b2b_wrb203", 1, 32'h0000_0203, ahb3_pkg::BYTE, $random(seed));
    add_vec("b2b_rdb200", 0, 32'h0000_0200, ahb3_pkg::WORD, '0);
  endtask

  ////////////////////////////////////////
  // Pipelined driver
  ////////////////////////////////////////

  task automatic drive_idle();
    req_i.hsel   = 1'b0;
    req_i.haddr  = '0;
    req_i.hwrite = 1'b0;
    req_i.hsize  = ahb3_pkg::WORD;
    req_i.htrans = ahb3_pkg::IDLE;
  endtask

  task automatic drive_addr(input vec_t v);
    req_i.hsel   = 1'b1;
    req_i.haddr  = v.addr;
    req_i.hwrite = v.hwrite;
    req_i.hsize  = v.size;
    req_i.htrans = ahb3_pkg::NONSEQ;
  endtask

  initial begin : stimulus
    int   issue;
    int   done;
    int   dp;
    logic stalled;
    logic hold;
    logic exp_ready;
    arst_n_i = 1'b0;
    hwdata_i = '0;
    drive_idle();
    build_table();
    cycle_limit = 4 * vec_q.size() + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    check_ready("reset_idle", 1'b1, rsp_o.hready);
    check_resp("reset_idle", ahb3_pkg::OKAY, rsp_o.hresp);
    check_word("reset_idle", '0, rsp_o.hrdata);
    issue   = 0;
    done    = 0;
    dp      = -1;
    stalled = 1'b0;
    while (done < vec_q.size()) begin
      @(negedge clk);
      hold = 1'b0;
      if (dp >= 0) begin
        hwdata_i = vec_q[dp].wdata;
        check_resp(name_q[dp], vec_q[dp].exp_resp, rsp_o.hresp);
        // Zero wait states, except the first cycle of an ERROR
        exp_ready = !(vec_q[dp].exp_resp == ahb3_pkg::ERROR && !stalled);
        check_ready(name_q[dp], exp_ready, rsp_o.hready);
        if (!rsp_o.hready) begin
          stalled = 1'b1;
        end else begin
          if (!vec_q[dp].hwrite && vec_q[dp].exp_resp == ahb3_pkg::OKAY) begin
            check_word(name_q[dp], vec_q[dp].exp_data, rsp_o.hrdata);
          end
          // Bus stays idle through the second error cycle
          hold    = stalled;
          stalled = 1'b0;
          done++;
          dp = -1;
        end
      end
      if (stalled || hold || issue >= vec_q.size()) begin
        drive_idle();
      end else begin
        drive_addr(vec_q[issue]);
        dp = issue;
        issue++;
      end
    end
    @(negedge clk);
    check_ready("final_idle", 1'b1, rsp_o.hready);
    check_resp("final_idle", ahb3_pkg::OKAY, rsp_o.hresp);
    $display("Regression passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
hw/ahb3_pkg.sv
hw/tile_map_pkg.sv
hw/ahb3_interconnect.sv
hw/ahb3_sram_sp.sv
hw/ahb3_bootrom.sv
hw/ahb3_tile.sv
verification/tb_ahb3_tile.sv
